// ==== source/uart_config.svh ====
//////////////////////////////////////////////////
// UART configuration
// Register map, line status bits and reset divisor
//////////////////////////////////////////////////

`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Register addresses on the 8-bit bus
`define UART_ADR_DATA 3'd0
`define UART_ADR_DIVL 3'd2
`define UART_ADR_DIVH 3'd3
`define UART_ADR_MCR  3'd4
`define UART_ADR_LSR  3'd5

// Modem control bits
`define UART_MCR_LOOP 4

// Line status bits
`define UART_LSR_DR   0
`define UART_LSR_OE   1
`define UART_LSR_FE   3
`define UART_LSR_THRE 5
`define UART_LSR_TEMT 6

// Clock cycles per bit out of reset
`define UART_DIV_RESET 16'd16

`endif

// ==== source/uart_pkg.sv ====
//////////////////////////////////////////////////
// UART package
// Shared vector types, transfer structs and FSM states
//////////////////////////////////////////////////

package uart_pkg;

  // Data byte on the bus and the serial line
  typedef logic [7:0] uart_byte_t;

  // Register address
  typedef logic [2:0] uart_addr_t;

  // Clock cycles in one bit period
  typedef logic [15:0] uart_div_t;

  // Register access issued by the bridge
  typedef struct packed {
    logic       we;
    logic       re;
    uart_addr_t adr;
    uart_byte_t dat;
  } reg_access_t;

  // Received frame report
  typedef struct packed {
    logic       valid;
    uart_byte_t data;
    logic       frame_err;
  } rx_event_t;

  // Bridge acknowledge FSM
  typedef enum logic [1:0] {BR_IDLE, BR_ACK, BR_HOLD1, BR_HOLD2} bridge_state_t;

  // Serial FSMs
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

// ==== source/uart_bridge_wb.sv ====
//////////////////////////////////////////////////
// UART Wishbone bridge
// Samples the classic bus, paces the acknowledge
// and issues single-cycle register strobes
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_bridge_wb (
  input  logic                  clk,
  input  logic                  wb_rst_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  uart_pkg::uart_addr_t  wb_adr_i,
  input  uart_pkg::uart_byte_t  wb_dat_i,
  output uart_pkg::uart_byte_t  wb_dat_o,
  output logic                  wb_ack_o,
  input  uart_pkg::uart_byte_t  rd_data_i,
  output uart_pkg::reg_access_t access_o
);

  // Sampled bus control
  logic cyc_s;
  logic stb_s;
  logic we_s;

  // Sampled address and write data
  uart_pkg::uart_addr_t adr_s;
  uart_pkg::uart_byte_t dat_s;

  uart_pkg::bridge_state_t state;

  logic req_s;

  //////////////////////////////////////////////////
  // Bus sampling
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      cyc_s <= 1'b0;
      stb_s <= 1'b0;
      we_s  <= 1'b0;
    end else begin
      cyc_s <= wb_cyc_i;
      stb_s <= wb_stb_i;
      we_s  <= wb_we_i;
    end
  end

  // Address and data follow the bus every cycle
  always_ff @(posedge clk) begin
    adr_s <= wb_adr_i;
    dat_s <= wb_dat_i;
  end

  assign req_s = stb_s & cyc_s;

  //////////////////////////////////////////////////
  // Acknowledge FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state    <= uart_pkg::BR_IDLE;
      wb_ack_o <= 1'b0;
    end else begin
      case (state)
        uart_pkg::BR_IDLE: begin
          // Ack one cycle after the sampled request
          if (req_s) begin
            wb_ack_o <= 1'b1;
            state    <= uart_pkg::BR_ACK;
          end
        end
        uart_pkg::BR_ACK: begin
          wb_ack_o <= 1'b0;
          state    <= uart_pkg::BR_HOLD1;
        end
        // Recovery cycles while the master drops stb
        uart_pkg::BR_HOLD1: state <= uart_pkg::BR_HOLD2;
        default:            state <= uart_pkg::BR_IDLE;
      endcase
    end
  end

  // Strobes only in the first sampled cycle
  assign access_o = '{we:  req_s & we_s & (state == uart_pkg::BR_IDLE),
                      re:  req_s & ~we_s & (state == uart_pkg::BR_IDLE),
                      adr: adr_s,
                      dat: dat_s};

  // Read data lands in the ack cycle
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wb_dat_o <= '0;
    end else begin
      wb_dat_o <= rd_data_i;
    end
  end

endmodule

// ==== source/uart_regs.sv ====
//////////////////////////////////////////////////
// UART register file
// Holding and receive bytes, divisor, MCR, line
// status and the bit-rate tick generator
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "uart_config.svh"

module uart_regs (
  input  logic                  clk,
  input  logic                  wb_rst_i,
  input  uart_pkg::reg_access_t access_i,
  output uart_pkg::uart_byte_t  rd_data_o,
  input  uart_pkg::rx_event_t   rx_evt_i,
  input  logic                  tx_busy_i,
  output logic                  tx_start_o,
  output uart_pkg::uart_byte_t  tx_data_o,
  output logic                  bit_tick_o,
  output logic                  loopback_o,
  output uart_pkg::uart_div_t   divisor_o
);

  uart_pkg::uart_byte_t thr;
  uart_pkg::uart_byte_t rbr;
  uart_pkg::uart_byte_t mcr;
  uart_pkg::uart_byte_t lsr;
  uart_pkg::uart_div_t  divisor;
  uart_pkg::uart_div_t  tick_cnt;

  // Status flags
  logic thr_full;
  logic dr;
  logic oe;
  logic fe;

  // Decoded strobes
  logic wr_thr;
  logic wr_div;
  logic rd_rbr;
  logic rd_lsr;

  assign wr_thr = access_i.we && (access_i.adr == `UART_ADR_DATA);
  assign wr_div = access_i.we && ((access_i.adr == `UART_ADR_DIVL) ||
                                  (access_i.adr == `UART_ADR_DIVH));
  assign rd_rbr = access_i.re && (access_i.adr == `UART_ADR_DATA);
  assign rd_lsr = access_i.re && (access_i.adr == `UART_ADR_LSR);

  // Hand the byte over on a tick so the start bit is full length
  assign tx_start_o = thr_full & ~tx_busy_i & bit_tick_o;
  assign tx_data_o  = thr;
  assign loopback_o = mcr[`UART_MCR_LOOP];
  assign divisor_o  = divisor;

  //////////////////////////////////////////////////
  // Control registers and flags
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      thr_full <= 1'b0;
      dr       <= 1'b0;
      oe       <= 1'b0;
      fe       <= 1'b0;
      mcr      <= '0;
      divisor  <= `UART_DIV_RESET;
    end else begin
      // A new write wins over the transmitter taking the byte
      if (wr_thr) thr_full <= 1'b1;
      else if (tx_start_o) thr_full <= 1'b0;

      if (access_i.we && (access_i.adr == `UART_ADR_DIVL)) divisor[7:0]  <= access_i.dat;
      if (access_i.we && (access_i.adr == `UART_ADR_DIVH)) divisor[15:8] <= access_i.dat;
      if (access_i.we && (access_i.adr == `UART_ADR_MCR)) mcr <= access_i.dat;

      // Receive events take priority over read clears
      if (rx_evt_i.valid) dr <= 1'b1;
      else if (rd_rbr) dr <= 1'b0;

      if (rx_evt_i.valid && dr && !rd_rbr) oe <= 1'b1;
      else if (rd_lsr) oe <= 1'b0;

      if (rx_evt_i.valid && rx_evt_i.frame_err) fe <= 1'b1;
      else if (rd_lsr) fe <= 1'b0;
    end
  end

  // Data bytes
  always_ff @(posedge clk) begin
    if (wr_thr) thr <= access_i.dat;
    // Newest byte overwrites an unread one
    if (rx_evt_i.valid) rbr <= rx_evt_i.data;
  end

  //////////////////////////////////////////////////
  // Bit-rate tick
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      tick_cnt   <= '0;
      bit_tick_o <= 1'b0;
    end else if (wr_div) begin
      // Restart the period on a new divisor
      tick_cnt   <= '0;
      bit_tick_o <= 1'b0;
    end else if (tick_cnt == divisor - 16'd1) begin
      tick_cnt   <= '0;
      bit_tick_o <= 1'b1;
    end else begin
      tick_cnt   <= tick_cnt + 16'd1;
      bit_tick_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Read decode
  //////////////////////////////////////////////////

  always_comb begin
    lsr                  = '0;
    lsr[`UART_LSR_DR]    = dr;
    lsr[`UART_LSR_OE]    = oe;
    lsr[`UART_LSR_FE]    = fe;
    lsr[`UART_LSR_THRE]  = ~thr_full;
    // Transmitter fully drained
    lsr[`UART_LSR_TEMT]  = ~thr_full & ~tx_busy_i;
  end

  always_comb begin
    case (access_i.adr)
      `UART_ADR_DATA: rd_data_o = rbr;
      `UART_ADR_DIVL: rd_data_o = divisor[7:0];
      `UART_ADR_DIVH: rd_data_o = divisor[15:8];
      `UART_ADR_MCR:  rd_data_o = mcr;
      `UART_ADR_LSR:  rd_data_o = lsr;
      default:        rd_data_o = '0;
    endcase
  end

endmodule

// ==== source/uart_tx.sv ====
//////////////////////////////////////////////////
// UART transmitter
// Sends 8N1 frames paced by the bit tick
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_tx (
  input  logic                 clk,
  input  logic                 wb_rst_i,
  input  logic                 bit_tick_i,
  input  logic                 start_i,
  input  uart_pkg::uart_byte_t data_i,
  output logic                 busy_o,
  output logic                 tx_o
);

  uart_pkg::tx_state_t  state;
  uart_pkg::uart_byte_t shreg;
  logic [2:0]           bit_cnt;

  assign busy_o = (state != uart_pkg::TX_IDLE);

  //////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state   <= uart_pkg::TX_IDLE;
      tx_o    <= 1'b1;
      bit_cnt <= '0;
    end else begin
      case (state)
        uart_pkg::TX_IDLE: begin
          // Start bit begins on the accepting tick
          if (start_i) begin
            state <= uart_pkg::TX_START;
            tx_o  <= 1'b0;
          end
        end
        uart_pkg::TX_START: begin
          if (bit_tick_i) begin
            state   <= uart_pkg::TX_DATA;
            tx_o    <= shreg[0];
            bit_cnt <= '0;
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_tick_i) begin
            if (bit_cnt == 3'd7) begin
              state <= uart_pkg::TX_STOP;
              tx_o  <= 1'b1;
            end else begin
              tx_o    <= shreg[0];
              bit_cnt <= bit_cnt + 3'd1;
            end
          end
        end
        default: begin
          // Stop bit held for one full period
          if (bit_tick_i) state <= uart_pkg::TX_IDLE;
        end
      endcase
    end
  end

  // Shift register, LSB goes out first
  always_ff @(posedge clk) begin
    if ((state == uart_pkg::TX_IDLE) && start_i) begin
      shreg <= data_i;
    end else if (bit_tick_i && ((state == uart_pkg::TX_START) ||
                                (state == uart_pkg::TX_DATA))) begin
      shreg <= {1'b0, shreg[7:1]};
    end
  end

endmodule

// ==== source/uart_rx.sv ====
//////////////////////////////////////////////////
// UART receiver
// Detects the start edge and samples each bit
// at mid-bit using the divisor
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_rx (
  input  logic                clk,
  input  logic                wb_rst_i,
  input  uart_pkg::uart_div_t divisor_i,
  input  logic                rx_i,
  output uart_pkg::rx_event_t evt_o
);

  uart_pkg::rx_state_t  state;
  uart_pkg::uart_div_t  cnt;
  uart_pkg::uart_div_t  half_last;
  uart_pkg::uart_div_t  full_last;
  uart_pkg::uart_byte_t shreg;
  uart_pkg::uart_byte_t evt_data;
  logic [2:0]           bit_cnt;

  // Synchronizer and edge history, idle high
  logic rx_meta;
  logic rx_sync;
  logic rx_prev;

  logic evt_valid;
  logic evt_fe;
  logic at_half;
  logic at_full;

  assign half_last = (divisor_i >> 1) - 16'd1;
  assign full_last = divisor_i - 16'd1;
  assign at_half   = (cnt == half_last);
  assign at_full   = (cnt == full_last);

  //////////////////////////////////////////////////
  // Receive FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      rx_meta   <= 1'b1;
      rx_sync   <= 1'b1;
      rx_prev   <= 1'b1;
      state     <= uart_pkg::RX_IDLE;
      cnt       <= '0;
      bit_cnt   <= '0;
      evt_valid <= 1'b0;
    end else begin
      rx_meta   <= rx_i;
      rx_sync   <= rx_meta;
      rx_prev   <= rx_sync;
      evt_valid <= 1'b0;
      case (state)
        uart_pkg::RX_IDLE: begin
          // Falling edge opens a frame
          if (rx_prev && !rx_sync) begin
            state <= uart_pkg::RX_START;
            cnt   <= '0;
          end
        end
        uart_pkg::RX_START: begin
          if (at_half) begin
            cnt     <= '0;
            bit_cnt <= '0;
            // High at mid-bit means a glitch
            state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end else begin
            cnt <= cnt + 16'd1;
          end
        end
        uart_pkg::RX_DATA: begin
          if (at_full) begin
            cnt <= '0;
            if (bit_cnt == 3'd7) state <= uart_pkg::RX_STOP;
            else bit_cnt <= bit_cnt + 3'd1;
          end else begin
            cnt <= cnt + 16'd1;
          end
        end
        default: begin
          // Report the frame at stop bit mid-point
          if (at_full) begin
            evt_valid <= 1'b1;
            state     <= uart_pkg::RX_IDLE;
          end else begin
            cnt <= cnt + 16'd1;
          end
        end
      endcase
    end
  end

  // Data shift and event payload
  always_ff @(posedge clk) begin
    if ((state == uart_pkg::RX_DATA) && at_full) shreg <= {rx_sync, shreg[7:1]};
    if ((state == uart_pkg::RX_STOP) && at_full) begin
      evt_data <= shreg;
      // Low stop bit is a framing error
      evt_fe   <= ~rx_sync;
    end
  end

  assign evt_o = '{valid: evt_valid, data: evt_data, frame_err: evt_fe};

endmodule

// ==== source/uart_top.sv ====
//////////////////////////////////////////////////
// UART top level
// Wishbone bridge, registers, serial engines and
// the loopback path
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_top (
  input  logic                 clk,
  input  logic                 wb_rst_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  uart_pkg::uart_addr_t wb_adr_i,
  input  uart_pkg::uart_byte_t wb_dat_i,
  output uart_pkg::uart_byte_t wb_dat_o,
  output logic                 wb_ack_o,
  input  logic                 rx_i,
  output logic                 tx_o
);

  uart_pkg::reg_access_t access;
  uart_pkg::uart_byte_t  rd_data;
  uart_pkg::rx_event_t   rx_evt;
  uart_pkg::uart_byte_t  tx_data;
  uart_pkg::uart_div_t   divisor;

  logic tx_busy;
  logic tx_start;
  logic bit_tick;
  logic loopback;
  logic rx_line;

  // Receiver listens to our own transmitter in loopback
  assign rx_line = loopback ? tx_o : rx_i;

  uart_bridge_wb u_bridge (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .rd_data_i (rd_data),
    .access_o  (access)
  );

  uart_regs u_regs (
    .clk        (clk),
    .wb_rst_i   (wb_rst_i),
    .access_i   (access),
    .rd_data_o  (rd_data),
    .rx_evt_i   (rx_evt),
    .tx_busy_i  (tx_busy),
    .tx_start_o (tx_start),
    .tx_data_o  (tx_data),
    .bit_tick_o (bit_tick),
    .loopback_o (loopback),
    .divisor_o  (divisor)
  );

  uart_tx u_tx (
    .clk        (clk),
    .wb_rst_i   (wb_rst_i),
    .bit_tick_i (bit_tick),
    .start_i    (tx_start),
    .data_i     (tx_data),
    .busy_o     (tx_busy),
    .tx_o       (tx_o)
  );

  uart_rx u_rx (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .divisor_i (divisor),
    .rx_i      (rx_line),
    .evt_o     (rx_evt)
  );

endmodule

// ==== test/uart_top_asserts.sv ====
//////////////////////////////////////////////////
// UART protocol assertions
// Acknowledge pacing, strobe timing and idle
// level of the serial output
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_top_asserts (
  input logic                  clk,
  input logic                  wb_rst_i,
  input logic                  ack_i,
  input uart_pkg::reg_access_t access_i,
  input logic                  tx_busy_i,
  input logic                  tx_i
);

  // Failure counts, one per property
  int ack_len_fails = 0;
  int ack_gap_fails = 0;
  int strobe_fails  = 0;
  int tx_idle_fails = 0;

  ack_one_cycle: assert property (@(posedge clk) disable iff (wb_rst_i) ack_i |=> !ack_i)
    else begin
      ack_len_fails = ack_len_fails + 1;
      $error("Acknowledge held for more than one cycle");
    end

  // Three recovery cycles between acknowledges
  ack_spacing: assert property (@(posedge clk) disable iff (wb_rst_i)
    ack_i |-> !($past(ack_i, 1) || $past(ack_i, 2) || $past(ack_i, 3)))
    else begin
      ack_gap_fails = ack_gap_fails + 1;
      $error("Acknowledge within three cycles of the previous one");
    end

  // A strobe lasts one cycle and the acknowledge follows it
  strobe_then_ack: assert property (@(posedge clk) disable iff (wb_rst_i)
    (access_i.we || access_i.re) |=> (ack_i && !access_i.we && !access_i.re))
    else begin
      strobe_fails = strobe_fails + 1;
      $error("Register strobe not a single cycle followed by the acknowledge");
    end

  tx_idle_high: assert property (@(posedge clk) disable iff (wb_rst_i) !tx_busy_i |-> tx_i)
    else begin
      tx_idle_fails = tx_idle_fails + 1;
      $error("Serial output low while the transmitter is idle");
    end

endmodule

bind uart_top uart_top_asserts u_asserts (
  .clk       (clk),
  .wb_rst_i  (wb_rst_i),
  .ack_i     (wb_ack_o),
  .access_i  (access),
  .tx_busy_i (tx_busy),
  .tx_i      (tx_o)
);

// ==== test/uart_top_tb.sv ====
//////////////////////////////////////////////////
// UART testbench
// Runs the vector file against the Wishbone port
// and the serial lines, with a frame monitor on tx
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "uart_config.svh"

module uart_top_tb;

  // DUT ports
  logic                 clk;
  logic                 wb_rst_i;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  logic                 wb_we_i;
  uart_pkg::uart_addr_t wb_adr_i;
  uart_pkg::uart_byte_t wb_dat_i;
  uart_pkg::uart_byte_t wb_dat_o;
  logic                 wb_ack_o;
  logic                 rx_i;
  logic                 tx_o;

  // Four bytes per vector: op, address, data, expected
  logic [7:0] vec_mem [0:511];

  // Divisor as last written over the bus
  uart_pkg::uart_div_t cur_div;

  // Captured tx frames, stop bit on top
  logic [8:0] tx_frames [$];
  uart_pkg::uart_byte_t mon_data;

  int cycle_cnt;
  int cycle_limit;
  int errors;
  int seed;

  uart_top uut (
    .clk      (clk),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .rx_i     (rx_i),
    .tx_o     (tx_o)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // Timeout and assertion watch
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: no progress after %0d clock cycles", cycle_cnt);
      $display("test failed");
      $fatal(1, "Run stopped by the cycle limit");
    end else if (assert_failures() != 0) begin
      $display("A bus or serial line assertion failed");
      $display("test failed");
      $fatal(1, "Run stopped by an assertion");
    end
  end

  // Serial monitor, samples tx at mid-bit on falling clock edges
  always begin
    @(negedge clk);
    if (tx_o === 1'b0) begin
      repeat (cur_div >> 1) @(negedge clk);
      // A start bit that is gone by mid-bit is ignored
      if (tx_o === 1'b0) begin
        for (int i = 0; i < 8; i++) begin
          repeat (cur_div) @(negedge clk);
          mon_data = {tx_o, mon_data[7:1]};
        end
        repeat (cur_div) @(negedge clk);
        tx_frames.push_back({tx_o, mon_data});
      end
    end
  end

  //////////////////////////////////////////////////
  // Tasks
  //////////////////////////////////////////////////

  // Failures counted by the bound assertion checker
  function automatic int assert_failures();
    return uut.u_asserts.ack_len_fails + uut.u_asserts.ack_gap_fails +
           uut.u_asserts.strobe_fails + uut.u_asserts.tx_idle_fails;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      errors = errors + 1;
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
      $display("test failed");
      $fatal(1, "Mismatch ends the run");
    end
  endtask

  // One classic cycle, entered and left 5 ns after a rising edge
  task automatic bus_access(input logic we, input uart_pkg::uart_addr_t adr,
                            input uart_pkg::uart_byte_t dat,
                            output uart_pkg::uart_byte_t rdata);
    int cycles;
    cycles   = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    do begin
      @(posedge clk);
      #5;
      cycles = cycles + 1;
    end while (!wb_ack_o);
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    check_value("ack latency", 2, cycles);
    // Bridge recovery
    repeat (3) begin
      @(posedge clk);
      #5;
    end
    if (we && (adr == `UART_ADR_DIVL)) cur_div[7:0] = dat;
    if (we && (adr == `UART_ADR_DIVH)) cur_div[15:8] = dat;
  endtask

  task automatic poll_bit(input uart_pkg::uart_addr_t adr, input logic [2:0] bit_idx,
                          input logic value);
    uart_pkg::uart_byte_t rd;
    bus_access(1'b0, adr, 8'h00, rd);
    while (rd[bit_idx] !== value) begin
      bus_access(1'b0, adr, 8'h00, rd);
    end
  endtask

  // 8N1 frame on rx, then one idle bit
  task automatic send_frame(input uart_pkg::uart_byte_t data, input logic stop_bit);
    logic [10:0] bits;
    bits = {1'b1, stop_bit, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
      rx_i = bits[0];
      bits = bits >> 1;
      repeat (cur_div) @(posedge clk);
      #5;
    end
  endtask

  task automatic expect_frame(input string name, input uart_pkg::uart_byte_t expected);
    logic [8:0] frame;
    while (tx_frames.size() == 0) begin
      @(posedge clk);
      #5;
    end
    frame = tx_frames.pop_front();
    check_value(name, int'({1'b1, expected}), int'(frame));
  endtask

  // Random bytes sent through the loopback path
  task automatic loop_echo(input string name, input int count);
    uart_pkg::uart_byte_t payload;
    uart_pkg::uart_byte_t rd;
    repeat (count) begin
      payload = 8'($random(seed));
      bus_access(1'b1, `UART_ADR_DATA, payload, rd);
      poll_bit(`UART_ADR_LSR, 3'(`UART_LSR_DR), 1'b1);
      bus_access(1'b0, `UART_ADR_DATA, 8'h00, rd);
      check_value(name, int'(payload), int'(rd));
    end
  endtask

  // Ten frames per vector at the divisor in force, plus margin
  function automatic int frame_budget();
    int                  total;
    uart_pkg::uart_div_t div;
    logic [8:0]          base;
    total = 200;
    div   = `UART_DIV_RESET;
    base  = '0;
    while (vec_mem[base] != 8'h00) begin
      if ((vec_mem[base] == 8'h01) && (vec_mem[base + 9'd1][2:0] == `UART_ADR_DIVL))
        div[7:0] = vec_mem[base + 9'd2];
      if ((vec_mem[base] == 8'h01) && (vec_mem[base + 9'd1][2:0] == `UART_ADR_DIVH))
        div[15:8] = vec_mem[base + 9'd2];
      total = total + 100 * int'(div);
      base  = base + 9'd4;
    end
    return total;
  endfunction

  task automatic run_vectors();
    int                   idx;
    logic [8:0]           base;
    logic [7:0]           op;
    logic [7:0]           adr;
    logic [7:0]           dat;
    logic [7:0]           exp;
    uart_pkg::uart_byte_t rd;
    string                name;
    idx  = 0;
    base = '0;
    op   = vec_mem[base];
    while (op != 8'h00) begin
      adr  = vec_mem[base + 9'd1];
      dat  = vec_mem[base + 9'd2];
      exp  = vec_mem[base + 9'd3];
      name = $sformatf("vector %0d op %0h adr %0h", idx, op, adr);
      case (op)
        8'h01: bus_access(1'b1, adr[2:0], dat, rd);
        8'h02: begin
          bus_access(1'b0, adr[2:0], 8'h00, rd);
          check_value(name, int'(exp), int'(rd));
        end
        8'h03: poll_bit(adr[2:0], dat[2:0], exp[0]);
        8'h04: send_frame(dat, exp[0]);
        8'h05: expect_frame(name, exp);
        8'h06: loop_echo(name, int'(dat));
        default: begin
          $display("Unknown operation %0h in vector %0d", op, idx);
          $display("test failed");
          $fatal(1, "Bad vector file");
        end
      endcase
      idx  = idx + 1;
      base = base + 9'd4;
      op   = vec_mem[base];
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    clk       = 1'b0;
    wb_rst_i  = 1'b1;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    rx_i      = 1'b1;
    seed      = 84;
    errors    = 0;
    cycle_cnt = 0;
    cur_div   = `UART_DIV_RESET;
    // Unused entries read as the end op
    foreach (vec_mem[i]) vec_mem[i] = 8'h00;
    $readmemh("test/uart_vectors.txt", vec_mem);
    cycle_limit = frame_budget();
    repeat (8) @(posedge clk);
    #5;
    wb_rst_i = 1'b0;
    run_vectors();
    if ((errors == 0) && (assert_failures() == 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== test/uart_vectors.txt ====
// op adr dat exp, hex. 1 write, 2 read and compare with exp, 3 poll bit dat of adr until exp
// 4 send dat on rx with stop bit exp, 5 expect byte exp on tx, 6 loopback dat random bytes, 0 end
// Reset values
02 05 00 60
02 04 00 00
02 02 00 10
02 03 00 00
// Divisor and MCR read back
01 02 04 00
01 03 00 00
02 02 00 04
02 03 00 00
01 04 0a 00
02 04 00 0a
01 04 00 00
// Transmit
01 00 a5 00
05 00 00 a5
03 05 06 01
02 05 00 60
01 00 3c 00
05 00 00 3c
03 05 06 01
// Receive
04 00 5a 01
03 05 00 01
02 05 00 61
02 00 00 5a
02 05 00 60
// Framing error
04 00 c3 00
02 05 00 69
02 05 00 61
02 00 00 c3
// Overrun
04 00 11 01
04 00 22 01
02 05 00 63
02 00 00 22
02 05 00 60
// Loopback
01 04 10 00
02 04 00 10
06 00 04 00
01 04 00 00
02 05 00 60
00 00 00 00

// ==== uart_top.f ====
+incdir+source
source/uart_pkg.sv
source/uart_bridge_wb.sv
source/uart_regs.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
test/uart_top_asserts.sv
test/uart_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f uart_top.f --top-module uart_top_tb -o uart_sim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/uart_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -qx "test passed" sim.log && echo "Simulation OK" \
  || { echo "Simulation FAILED, see sim.log"; exit 1; }
